// ==== sources.f ====
hw/rvMemPkg.sv
hw/storeAligner.sv
hw/dataRam.sv
hw/loadAligner.sv
hw/memStage.sv
verif/memStageTb.sv

// ==== run.sh ====
#!/bin/sh
# build and run the memStage testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --top-module memStageTb -f sources.f -o memStageSim \
	|| { echo "build failed"; exit 1; }

simOut=$(./obj_dir/memStageSim)
printf '%s\n' "$simOut"

printf '%s\n' "$simOut" | grep -qx "NO ERRORS" && echo "simulation passed" && exit 0 \
	|| { echo "simulation failed"; exit 1; }

// ==== verif/memStageTb.sv ====
`timescale 1ns/1ps

module memStageTb;

	localparam int TableLen = 36;
	localparam int RandWords = 16; // window words that get a known store first
	localparam int RandCount = 200;
	localparam int CycleLimit = (TableLen + RandWords + RandCount) * 2 + 100;
	localparam int RandBaseWord = 64; // window starts at byte 0x100

	typedef struct packed {
		logic write;
		logic [2:0] funct3;
		logic [rvMemPkg::AddrWidth-1:0] addr;
		logic [rvMemPkg::DataWidth-1:0] wData;
		logic [rvMemPkg::DataWidth-1:0] expData;
		logic expError;
	} stimEntry_t;

	logic clk;
	logic rst;
	logic reqValid;
	logic reqWrite;
	rvMemPkg::memFunct3_e reqFunct3;
	logic [rvMemPkg::AddrWidth-1:0] reqAddr;
	logic [rvMemPkg::DataWidth-1:0] reqWData;
	logic rspValid;
	logic [rvMemPkg::DataWidth-1:0] rspData;
	logic rspError;

	stimEntry_t stimTable [TableLen];
	int fillCount = 0;
	int errorCount = 0;
	int cycleCount = 0;

	// expected response of the request issued on the previous falling edge
	logic pendValid = 1'b0;
	logic [rvMemPkg::DataWidth-1:0] pendData;
	logic pendError;

	logic [7:0] modelMem [0:4095]; // byte model of the 4 KiB window

	memStage i_memStage (
		.clk(clk),
		.rst(rst),
		.reqValid(reqValid),
		.reqWrite(reqWrite),
		.reqFunct3(reqFunct3),
		.reqAddr(reqAddr),
		.reqWData(reqWData),
		.rspValid(rspValid),
		.rspData(rspData),
		.rspError(rspError)
	);

	initial
	begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	always @(posedge clk)
	begin
		cycleCount = cycleCount + 1;
		if (cycleCount >= CycleLimit)
		begin
			$display("timeout: run did not finish within %0d cycles", CycleLimit);
			$display("ERRORS FOUND");
			$finish;
		end
	end

	task automatic compareWord(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		if (actual !== expected)
		begin
			errorCount++;
			$display("ERROR at %0d ns: %s expected %h, got %h", $time, name, expected, actual);
		end
	endtask

	task automatic compareBit(input string name, input logic expected, input logic actual);
		if (actual !== expected)
		begin
			errorCount++;
			$display("ERROR at %0d ns: %s expected %b, got %b", $time, name, expected, actual);
		end
	endtask

	// response must show up exactly one edge after its request
	task automatic checkResponse();
		if (pendValid)
		begin
			if (rspValid !== 1'b1)
			begin
				errorCount++;
				$display("at %0d ns: no response for the request of the previous cycle", $time);
			end
			else
			begin
				compareWord("rspData", pendData, rspData);
				compareBit("rspError", pendError, rspError);
			end
		end
		else
		begin
			if (rspValid !== 1'b0)
			begin
				errorCount++;
				$display("at %0d ns: response seen without a request", $time);
			end
			compareWord("rspData", 32'h0, rspData); // idle outputs stay quiet
			compareBit("rspError", 1'b0, rspError);
		end
	endtask

	task automatic driveRequest(input logic write, input logic [2:0] funct3,
		input logic [31:0] addr, input logic [31:0] wData,
		input logic [31:0] expData, input logic expError);
		@(negedge clk);
		checkResponse();
		reqValid = 1'b1;
		reqWrite = write;
		reqFunct3 = rvMemPkg::memFunct3_e'(funct3); // illegal codes 3, 6, 7 pass through
		reqAddr = addr;
		reqWData = wData;
		pendValid = 1'b1;
		pendData = expData;
		pendError = expError;
	endtask

	task automatic idleCycle(input logic badCode);
		@(negedge clk);
		checkResponse();
		reqValid = 1'b0;
		reqWrite = 1'b0;
		if (badCode)
		begin
			reqFunct3 = rvMemPkg::memFunct3_e'(3'd3); // loadBad high without a request
		end
		else
		begin
			reqFunct3 = rvMemPkg::F3Byte;
		end
		reqAddr = '0;
		reqWData = '0;
		pendValid = 1'b0;
	endtask

	task automatic addEntry(input logic write, input logic [2:0] funct3,
		input logic [31:0] addr, input logic [31:0] wData,
		input logic [31:0] expData, input logic expError);
		if (fillCount < TableLen)
		begin
			stimTable[fillCount] = {write, funct3, addr, wData, expData, expError};
		end
		fillCount++;
	endtask

	task automatic fillTable();
		// sw then lw on one word
		addEntry(1'b1, 3'd2, 32'h000, 32'h12345678, 32'h0, 1'b0);
		addEntry(1'b0, 3'd2, 32'h000, 32'h0, 32'h12345678, 1'b0);
		// sb per lane while the other lanes survive
		addEntry(1'b1, 3'd2, 32'h004, 32'hAABBCCDD, 32'h0, 1'b0);
		addEntry(1'b1, 3'd0, 32'h004, 32'h00000081, 32'h0, 1'b0);
		addEntry(1'b0, 3'd2, 32'h004, 32'h0, 32'hAABBCC81, 1'b0);
		addEntry(1'b1, 3'd0, 32'h005, 32'h0000007F, 32'h0, 1'b0);
		addEntry(1'b1, 3'd0, 32'h006, 32'h123456F0, 32'h0, 1'b0);
		addEntry(1'b1, 3'd0, 32'h007, 32'hFFFFFF05, 32'h0, 1'b0);
		addEntry(1'b0, 3'd2, 32'h004, 32'h0, 32'h05F07F81, 1'b0);
		addEntry(1'b0, 3'd0, 32'h004, 32'h0, 32'hFFFFFF81, 1'b0);
		addEntry(1'b0, 3'd4, 32'h004, 32'h0, 32'h00000081, 1'b0);
		addEntry(1'b0, 3'd0, 32'h005, 32'h0, 32'h0000007F, 1'b0);
		addEntry(1'b0, 3'd4, 32'h005, 32'h0, 32'h0000007F, 1'b0);
		addEntry(1'b0, 3'd0, 32'h006, 32'h0, 32'hFFFFFFF0, 1'b0);
		addEntry(1'b0, 3'd4, 32'h006, 32'h0, 32'h000000F0, 1'b0);
		addEntry(1'b0, 3'd0, 32'h007, 32'h0, 32'h00000005, 1'b0);
		addEntry(1'b0, 3'd4, 32'h007, 32'h0, 32'h00000005, 1'b0);
		// halfwords at offsets 0 and 2
		addEntry(1'b1, 3'd1, 32'h008, 32'hFFFF1234, 32'h0, 1'b0);
		addEntry(1'b1, 3'd1, 32'h00A, 32'h0000C3A5, 32'h0, 1'b0);
		addEntry(1'b0, 3'd1, 32'h008, 32'h0, 32'h00001234, 1'b0);
		addEntry(1'b0, 3'd5, 32'h008, 32'h0, 32'h00001234, 1'b0);
		addEntry(1'b0, 3'd1, 32'h00A, 32'h0, 32'hFFFFC3A5, 1'b0);
		addEntry(1'b0, 3'd5, 32'h00A, 32'h0, 32'h0000C3A5, 1'b0);
		addEntry(1'b0, 3'd2, 32'h008, 32'h0, 32'hC3A51234, 1'b0);
		// misaligned and illegal accesses leave the word alone
		addEntry(1'b1, 3'd2, 32'h00C, 32'h0BADF00D, 32'h0, 1'b0);
		addEntry(1'b1, 3'd1, 32'h00D, 32'hFFFFFFFF, 32'h0, 1'b1);
		addEntry(1'b1, 3'd2, 32'h00E, 32'hFFFFFFFF, 32'h0, 1'b1);
		addEntry(1'b1, 3'd4, 32'h00C, 32'hFFFFFFFF, 32'h0, 1'b1);
		addEntry(1'b1, 3'd3, 32'h00C, 32'hFFFFFFFF, 32'h0, 1'b1);
		addEntry(1'b1, 3'd6, 32'h00C, 32'hFFFFFFFF, 32'h0, 1'b1);
		addEntry(1'b0, 3'd2, 32'h00E, 32'h0, 32'h0, 1'b1);
		addEntry(1'b0, 3'd7, 32'h00C, 32'h0, 32'h0, 1'b1);
		addEntry(1'b0, 3'd1, 32'h00F, 32'h0, 32'h0, 1'b1);
		addEntry(1'b0, 3'd2, 32'h00C, 32'h0, 32'h0BADF00D, 1'b0);
		// bits above the 4 KiB window are ignored
		addEntry(1'b1, 3'd2, 32'hFFFFF010, 32'h55AA33CC, 32'h0, 1'b0);
		addEntry(1'b0, 3'd2, 32'h00000010, 32'h0, 32'h55AA33CC, 1'b0);
	endtask

	// RV32I load/store rules applied to the byte model
	task automatic modelAccess(input logic write, input logic [2:0] funct3,
		input logic [31:0] addr, input logic [31:0] wData,
		output logic [31:0] expData, output logic expError);
		logic [11:0] a;
		logic legal;
		logic misaligned;
		logic [7:0] byteVal;
		logic [15:0] halfVal;
		logic [31:0] wordVal;
		a = addr[11:0];
		if (write)
		begin
			legal = (funct3 == 3'd0) || (funct3 == 3'd1) || (funct3 == 3'd2);
		end
		else
		begin
			legal = (funct3 != 3'd3) && (funct3 != 3'd6) && (funct3 != 3'd7);
		end
		misaligned = ((funct3 == 3'd1 || funct3 == 3'd5) && a[0]) ||
			(funct3 == 3'd2 && a[1:0] != 2'b00);
		expError = !legal || misaligned;
		expData = '0;
		if (!expError && write)
		begin
			modelMem[a] = wData[7:0];
			if (funct3 != 3'd0)
			begin
				modelMem[a + 12'd1] = wData[15:8];
			end
			if (funct3 == 3'd2)
			begin
				modelMem[a + 12'd2] = wData[23:16];
				modelMem[a + 12'd3] = wData[31:24];
			end
		end
		else if (!expError)
		begin
			byteVal = modelMem[a];
			halfVal = {modelMem[a + 12'd1], modelMem[a]};
			wordVal = {modelMem[a + 12'd3], modelMem[a + 12'd2], halfVal};
			case (funct3)
				3'd0: expData = {{24{byteVal[7]}}, byteVal};
				3'd1: expData = {{16{halfVal[15]}}, halfVal};
				3'd2: expData = wordVal;
				3'd4: expData = {24'h0, byteVal};
				3'd5: expData = {16'h0, halfVal};
				default: expData = '0;
			endcase
		end
	endtask

	task automatic randomRequest(input logic forceStore, input int wordIdx);
		int pick;
		int offset;
		logic write;
		logic [2:0] funct3;
		logic [31:0] upper;
		logic [31:0] addr;
		logic [31:0] wData;
		logic [31:0] expData;
		logic expError;
		pick = $urandom_range(0, 1);
		write = forceStore | pick[0];
		pick = $urandom_range(0, 9);
		if (forceStore)
		begin
			funct3 = 3'd2;
		end
		else if (pick < 8)
		begin
			pick = write ? $urandom_range(0, 2) : $urandom_range(0, 4);
			funct3 = (pick > 2) ? pick[2:0] + 3'd1 : pick[2:0]; // skip code 3
		end
		else
		begin
			pick = $urandom_range(0, 7); // any code including illegal ones
			funct3 = pick[2:0];
		end
		offset = forceStore ? 0 : $urandom_range(0, 3);
		pick = $urandom_range(0, 1);
		if (pick == 1 && (funct3 == 3'd1 || funct3 == 3'd5))
		begin
			offset = offset & 2; // half of the time keep it aligned
		end
		if (pick == 1 && funct3 == 3'd2)
		begin
			offset = 0;
		end
		upper = $urandom();
		addr = {upper[31:12], wordIdx[9:0], offset[1:0]};
		wData = $urandom();
		modelAccess(write, funct3, addr, wData, expData, expError);
		driveRequest(write, funct3, addr, wData, expData, expError);
	endtask

	initial
	begin
		void'($urandom(24574));
		rst = 1'b1;
		reqValid = 1'b0;
		reqWrite = 1'b0;
		reqFunct3 = rvMemPkg::F3Byte;
		reqAddr = '0;
		reqWData = '0;
		fillTable();
		if (fillCount != TableLen)
		begin
			errorCount++;
			$display("stimulus table holds %0d entries instead of %0d", fillCount, TableLen);
		end
		repeat (8) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;
		idleCycle(1'b0); // outputs quiet after reset
		idleCycle(1'b1);
		idleCycle(1'b0);
		for (int i = 0; i < TableLen; i++)
		begin
			driveRequest(stimTable[i].write, stimTable[i].funct3, stimTable[i].addr,
				stimTable[i].wData, stimTable[i].expData, stimTable[i].expError);
		end
		idleCycle(1'b1);
		idleCycle(1'b0);
		for (int w = 0; w < RandWords; w++)
		begin
			randomRequest(1'b1, RandBaseWord + w); // known contents before the mix
		end
		for (int n = 0; n < RandCount; n++)
		begin
			randomRequest(1'b0, RandBaseWord + $urandom_range(0, RandWords - 1));
		end
		idleCycle(1'b0);
		idleCycle(1'b0);
		$display("memStage run finished with %0d errors", errorCount);
		if (errorCount == 0)
		begin
			$display("NO ERRORS");
		end
		else
		begin
			$display("ERRORS FOUND");
		end
		$finish;
	end

endmodule

// ==== hw/memStage.sv ====
`timescale 1ns/1ps

module memStage (
	input logic clk,
	input logic rst,
	input logic reqValid,
	input logic reqWrite,
	input rvMemPkg::memFunct3_e reqFunct3,
	input logic [rvMemPkg::AddrWidth-1:0] reqAddr,
	input logic [rvMemPkg::DataWidth-1:0] reqWData,
	output logic rspValid,
	output logic [rvMemPkg::DataWidth-1:0] rspData,
	output logic rspError
);

	// request side
	logic [rvMemPkg::OffsetBits-1:0] reqOffset;
	logic [rvMemPkg::RamAddrBits-1:0] reqWordAddr;
	logic [rvMemPkg::ByteLanes-1:0] byteEn;
	logic [rvMemPkg::DataWidth-1:0] laneData;
	logic storeBad;
	logic writeEn;

	// response stage, lines up with the RAM read latency
	logic rspStageValid;
	logic rspStageWrite;
	logic rspStageStoreBad;
	rvMemPkg::memFunct3_e rspStageFunct3;
	logic [rvMemPkg::OffsetBits-1:0] rspStageOffset;

	logic [rvMemPkg::DataWidth-1:0] ramRData;
	logic [rvMemPkg::DataWidth-1:0] loadData;
	logic loadBad;
	logic goodLoad;

	// upper address bits above the 4 KiB window are ignored
	assign reqOffset = reqAddr[rvMemPkg::OffsetBits-1:0];
	assign reqWordAddr = reqAddr[rvMemPkg::OffsetBits +: rvMemPkg::RamAddrBits];

	storeAligner i_storeAligner (
		.funct3(reqFunct3),
		.offset(reqOffset),
		.wData(reqWData),
		.byteEn(byteEn),
		.laneData(laneData),
		.storeBad(storeBad)
	);

	// bad stores leave memory untouched
	assign writeEn = reqValid & reqWrite & ~storeBad;

	dataRam i_dataRam (
		.clk(clk),
		.wordAddr(reqWordAddr),
		.writeEn(writeEn),
		.byteEn(byteEn),
		.wData(laneData),
		.rData(ramRData)
	);

	// control bits of the response stage
	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			rspStageValid <= 1'b0;
			rspStageWrite <= 1'b0;
			rspStageStoreBad <= 1'b0;
		end
		else
		begin
			rspStageValid <= reqValid;
			rspStageWrite <= reqWrite;
			rspStageStoreBad <= storeBad;
		end
	end

	// side-band that travels with the read word
	always_ff @(posedge clk)
	begin
		rspStageFunct3 <= reqFunct3;
		rspStageOffset <= reqOffset;
	end

	loadAligner i_loadAligner (
		.funct3(rspStageFunct3),
		.offset(rspStageOffset),
		.rWord(ramRData),
		.loadData(loadData),
		.loadBad(loadBad)
	);

	assign goodLoad = rspStageValid & ~rspStageWrite & ~loadBad;

	// Response is one cycle after the request. Error source depends
	// on the direction; data is only shown for a good load.
	always_comb
	begin
		rspValid = rspStageValid;
		if (rspStageWrite)
		begin
			rspError = rspStageValid & rspStageStoreBad;
		end
		else
		begin
			rspError = rspStageValid & loadBad;
		end
		if (goodLoad)
		begin
			rspData = loadData;
		end
		else
		begin
			rspData = '0; // stores and errors return zero
		end
	end

endmodule

// ==== hw/loadAligner.sv ====
`timescale 1ns/1ps

module loadAligner (
	input rvMemPkg::memFunct3_e funct3,
	input logic [rvMemPkg::OffsetBits-1:0] offset,
	input logic [rvMemPkg::DataWidth-1:0] rWord,
	output logic [rvMemPkg::DataWidth-1:0] loadData,
	output logic loadBad
);

	logic [rvMemPkg::DataWidth-1:0] shifted; // addressed lane moved to bit 0
	logic [rvMemPkg::ByteWidth-1:0] loByte;
	logic [rvMemPkg::HalfWidth-1:0] loHalf;
	logic codeBad;
	logic alignBad;

	// offset is in bytes, shift by offset * 8
	assign shifted = rWord >> {offset, 3'b000};
	assign loByte = shifted[rvMemPkg::ByteWidth-1:0];
	assign loHalf = shifted[rvMemPkg::HalfWidth-1:0];

	always_comb
	begin
		codeBad = 1'b0;
		case (funct3)
			rvMemPkg::F3Byte:
			begin
				// lb
				loadData = {{(rvMemPkg::DataWidth - rvMemPkg::ByteWidth){loByte[7]}}, loByte};
			end
			rvMemPkg::F3Half:
			begin
				// lh
				loadData = {{(rvMemPkg::DataWidth - rvMemPkg::HalfWidth){loHalf[15]}}, loHalf};
			end
			rvMemPkg::F3Word:
			begin
				loadData = rWord; // lw, offset must be zero
			end
			rvMemPkg::F3ByteU:
			begin
				loadData = {{(rvMemPkg::DataWidth - rvMemPkg::ByteWidth){1'b0}}, loByte};
			end
			rvMemPkg::F3HalfU:
			begin
				loadData = {{(rvMemPkg::DataWidth - rvMemPkg::HalfWidth){1'b0}}, loHalf};
			end
			default:
			begin
				loadData = '0;
				codeBad = 1'b1; // codes 3, 6, 7
			end
		endcase
	end

	assign alignBad = rvMemPkg::isMisaligned(funct3, offset);
	assign loadBad = codeBad | alignBad;

endmodule

// ==== hw/dataRam.sv ====
`timescale 1ns/1ps

module dataRam (
	input logic clk,
	input logic [rvMemPkg::RamAddrBits-1:0] wordAddr,
	input logic writeEn,
	input logic [rvMemPkg::ByteLanes-1:0] byteEn,
	input logic [rvMemPkg::DataWidth-1:0] wData,
	output logic [rvMemPkg::DataWidth-1:0] rData
);

	// single array so synthesis maps it onto byte-write block RAM
	logic [rvMemPkg::DataWidth-1:0] mem [0:rvMemPkg::RamDepth-1];

	// byte-enabled write, applied at the edge
	always_ff @(posedge clk)
	begin
		if (writeEn)
		begin
			for (int lane = 0; lane < rvMemPkg::ByteLanes; lane++)
			begin
				if (byteEn[lane])
				begin
					mem[wordAddr][lane*rvMemPkg::ByteWidth +: rvMemPkg::ByteWidth] <=
						wData[lane*rvMemPkg::ByteWidth +: rvMemPkg::ByteWidth];
				end
			end
		end
	end

	// Registered read every cycle. A read of the word being written
	// in the same cycle returns the old contents.
	always_ff @(posedge clk)
	begin
		rData <= mem[wordAddr];
	end

endmodule

// ==== hw/storeAligner.sv ====
`timescale 1ns/1ps

module storeAligner (
	input rvMemPkg::memFunct3_e funct3,
	input logic [rvMemPkg::OffsetBits-1:0] offset,
	input logic [rvMemPkg::DataWidth-1:0] wData,
	output logic [rvMemPkg::ByteLanes-1:0] byteEn,
	output logic [rvMemPkg::DataWidth-1:0] laneData,
	output logic storeBad
);

	logic [rvMemPkg::ByteLanes-1:0] laneMask; // enables before the offset shift
	logic codeBad; // not a store width code
	logic alignBad;

	// replicate the store value so every lane carries it
	always_comb
	begin
		laneMask = '0;
		laneData = wData;
		codeBad = 1'b0;
		case (funct3)
			rvMemPkg::F3Byte:
			begin
				laneMask = rvMemPkg::LaneByte;
				laneData = {rvMemPkg::ByteLanes{wData[rvMemPkg::ByteWidth-1:0]}};
			end
			rvMemPkg::F3Half:
			begin
				laneMask = rvMemPkg::LaneHalf;
				laneData = {(rvMemPkg::ByteLanes / 2){wData[rvMemPkg::HalfWidth-1:0]}};
			end
			rvMemPkg::F3Word:
			begin
				laneMask = rvMemPkg::LaneWord;
			end
			default:
			begin
				codeBad = 1'b1; // lbu/lhu codes and 3, 6, 7
			end
		endcase
	end

	assign alignBad = rvMemPkg::isMisaligned(funct3, offset);
	assign storeBad = codeBad | alignBad;

	// a bad store must not touch any lane
	always_comb
	begin
		if (storeBad)
		begin
			byteEn = '0;
		end
		else
		begin
			byteEn = laneMask << offset; // move mask onto addressed lanes
		end
	end

endmodule

// ==== hw/rvMemPkg.sv ====
package rvMemPkg;

	// datapath widths
	localparam int DataWidth = 32;
	localparam int AddrWidth = 32; // byte address, upper bits ignored
	localparam int ByteWidth = 8;
	localparam int HalfWidth = 16;
	localparam int ByteLanes = DataWidth / ByteWidth; // one enable per lane

	// address split: word index sits above the byte offset
	localparam int OffsetBits = 2;
	localparam int RamAddrBits = 10; // addr[11:2]
	localparam int RamDepth = 1 << RamAddrBits; // 1024 words, 4 KiB

	// lane masks before shifting to the addressed lane
	localparam logic [ByteLanes-1:0] LaneByte = 4'b0001;
	localparam logic [ByteLanes-1:0] LaneHalf = 4'b0011;
	localparam logic [ByteLanes-1:0] LaneWord = 4'b1111;

	// RV32I load/store width field (funct3)
	typedef enum logic [2:0]
	{
		F3Byte = 3'd0, // lb / sb
		F3Half = 3'd1, // lh / sh
		F3Word = 3'd2, // lw / sw
		F3ByteU = 3'd4, // lbu, loads only
		F3HalfU = 3'd5 // lhu, loads only
	} memFunct3_e;

	// Natural alignment rule shared by both directions.
	// Byte accesses are never misaligned; codes that are illegal
	// for a direction are caught by the aligner itself.
	function automatic logic isMisaligned(
		input memFunct3_e funct3,
		input logic [OffsetBits-1:0] offset
	);
		logic bad;
		bad = 1'b0;
		case (funct3)
			F3Half, F3HalfU: bad = offset[0]; // halfword needs even address
			F3Word: bad = |offset; // word needs multiple of four
			default: bad = 1'b0;
		endcase
		return bad;
	endfunction

endpackage
